/* src/mips_pkg.sv */
`default_nettype none

package mips_pkg;

  typedef logic [31:0] word_t;     // data and address word
  typedef logic [4:0]  reg_addr_t; // register number

  localparam reg_addr_t REG_V0 = 5'd2;
  localparam reg_addr_t REG_V3 = 5'd3;

  typedef enum logic [5:0] {
    OP_SPECIAL = 6'h00, // r-type selected by funct
    OP_J       = 6'h02,
    OP_JAL     = 6'h03,
    OP_BEQ     = 6'h04,
    OP_BNE     = 6'h05,
    OP_ADDIU   = 6'h09,
    OP_SLTI    = 6'h0a,
    OP_ANDI    = 6'h0c,
    OP_ORI     = 6'h0d,
    OP_XORI    = 6'h0e,
    OP_LUI     = 6'h0f,
    OP_LW      = 6'h23,
    OP_SW      = 6'h2b
  } opcode_t;

  typedef enum logic [5:0] {
    FN_SLL  = 6'h00,
    FN_SRL  = 6'h02,
    FN_JR   = 6'h08,
    FN_ADDU = 6'h21,
    FN_SUBU = 6'h23,
    FN_AND  = 6'h24,
    FN_OR   = 6'h25,
    FN_XOR  = 6'h26,
    FN_SLT  = 6'h2a,
    FN_SLTU = 6'h2b
  } funct_t;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
    ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL, ALU_LUI
  } alu_op_t;

  typedef enum logic [1:0] {DST_RT, DST_RD, DST_RA} dst_sel_t;
  typedef enum logic [1:0] {WB_ALU, WB_MEM, WB_LINK} wb_sel_t;

  typedef struct packed {
    logic     reg_write;
    dst_sel_t dst_sel;      // rt for i-type, rd for r-type, ra for jal
    wb_sel_t  wb_sel;
    logic     alu_src_imm;  // b operand from the immediate
    logic     imm_zero_ext; // logical immediates are zero extended
    alu_op_t  alu_op;
    logic     mem_read;
    logic     mem_write;
    logic     branch_eq;
    logic     branch_ne;
    logic     jump;
    logic     jump_reg;
  } ctrl_t;

endpackage

`default_nettype wire

/* src/mips_alu.sv */
`timescale 1ns/1ps
`default_nettype none

module mips_alu import mips_pkg::*; (
  input  alu_op_t    op,
  input  word_t      a,
  input  word_t      b,
  input  logic [4:0] shamt,
  output word_t      result,
  output logic       zero
);

  logic lt_signed;
  logic lt_unsigned;

  assign lt_signed   = $signed(a) < $signed(b);
  assign lt_unsigned = a < b;

  always_comb begin
    case (op)
      ALU_ADD:  result = a + b; // no overflow trap
      ALU_SUB:  result = a - b;
      ALU_AND:  result = a & b;
      ALU_OR:   result = a | b;
      ALU_XOR:  result = a ^ b;
      ALU_SLT:  result = {31'b0, lt_signed};
      ALU_SLTU: result = {31'b0, lt_unsigned};
      ALU_SLL:  result = b << shamt; // shifts act on rt
      ALU_SRL:  result = b >> shamt;
      ALU_LUI:  result = {b[15:0], 16'h0000};
      default:  result = '0;
    endcase
  end

  assign zero = (result == '0);

endmodule

`default_nettype wire

/* src/mips_regfile.sv */
`timescale 1ns/1ps
`default_nettype none

module mips_regfile import mips_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      we,
  input  reg_addr_t ra1,
  input  reg_addr_t ra2,
  input  reg_addr_t wa,
  input  word_t     wd,
  output word_t     rd1,
  output word_t     rd2,
  output word_t     register_v0,
  output word_t     register_v3
);

  word_t regs [32];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we && (wa != '0)) begin // $zero stays zero
      regs[wa] <= wd;
    end
  end

  assign rd1 = regs[ra1];
  assign rd2 = regs[ra2];

  assign register_v0 = regs[REG_V0]; // observation taps
  assign register_v3 = regs[REG_V3];

endmodule

`default_nettype wire

/* src/mips_controller.sv */
`timescale 1ns/1ps
`default_nettype none

module mips_controller import mips_pkg::*; (
  input  word_t instr,
  output ctrl_t ctrl
);

  opcode_t opcode;
  funct_t  funct;

  assign opcode = opcode_t'(instr[31:26]);
  assign funct  = funct_t'(instr[5:0]);

  always_comb begin
    ctrl        = '0; // anything unlisted falls through as a no-op
    ctrl.alu_op = ALU_ADD;
    case (opcode)
      OP_SPECIAL: begin
        ctrl.dst_sel   = DST_RD;
        ctrl.reg_write = 1'b1;
        case (funct)
          FN_ADDU: ctrl.alu_op = ALU_ADD;
          FN_SUBU: ctrl.alu_op = ALU_SUB;
          FN_AND:  ctrl.alu_op = ALU_AND;
          FN_OR:   ctrl.alu_op = ALU_OR;
          FN_XOR:  ctrl.alu_op = ALU_XOR;
          FN_SLT:  ctrl.alu_op = ALU_SLT;
          FN_SLTU: ctrl.alu_op = ALU_SLTU;
          FN_SLL:  ctrl.alu_op = ALU_SLL;
          FN_SRL:  ctrl.alu_op = ALU_SRL;
          FN_JR: begin
            ctrl.reg_write = 1'b0;
            ctrl.jump_reg  = 1'b1; // target comes from rs
          end
          default: ctrl.reg_write = 1'b0;
        endcase
      end
      OP_ADDIU, OP_SLTI: begin
        ctrl.reg_write   = 1'b1;
        ctrl.alu_src_imm = 1'b1;
        ctrl.alu_op      = (opcode == OP_SLTI) ? ALU_SLT : ALU_ADD;
      end
      OP_ANDI, OP_ORI, OP_XORI, OP_LUI: begin
        ctrl.reg_write    = 1'b1;
        ctrl.alu_src_imm  = 1'b1;
        ctrl.imm_zero_ext = 1'b1;
        case (opcode)
          OP_ANDI: ctrl.alu_op = ALU_AND;
          OP_ORI:  ctrl.alu_op = ALU_OR;
          OP_XORI: ctrl.alu_op = ALU_XOR;
          default: ctrl.alu_op = ALU_LUI;
        endcase
      end
      OP_LW: begin
        ctrl.reg_write   = 1'b1;
        ctrl.alu_src_imm = 1'b1; // base + offset
        ctrl.mem_read    = 1'b1;
        ctrl.wb_sel      = WB_MEM;
      end
      OP_SW: begin
        ctrl.alu_src_imm = 1'b1;
        ctrl.mem_write   = 1'b1;
      end
      OP_BEQ: begin
        ctrl.alu_op    = ALU_SUB; // zero flag compares rs and rt
        ctrl.branch_eq = 1'b1;
      end
      OP_BNE: begin
        ctrl.alu_op    = ALU_SUB;
        ctrl.branch_ne = 1'b1;
      end
      OP_J: ctrl.jump = 1'b1;
      OP_JAL: begin
        ctrl.jump      = 1'b1;
        ctrl.reg_write = 1'b1;
        ctrl.dst_sel   = DST_RA;
        ctrl.wb_sel    = WB_LINK; // ra gets pc + 4
      end
      default: ;
    endcase
  end

  always_comb begin
    a_mem_excl: assert final (!(ctrl.mem_read && ctrl.mem_write))
      else $error("load and store decoded for one instruction");
  end

endmodule

`default_nettype wire

/* src/mips_datapath.sv */
`timescale 1ns/1ps
`default_nettype none

module mips_datapath import mips_pkg::*; #(
  parameter word_t RESET_VECTOR = 32'hbfc0_0000
) (
  input  logic  clk,
  input  logic  rst_n,
  input  logic  clk_enable,
  input  ctrl_t ctrl,
  input  word_t instr_readdata,
  input  word_t data_readdata,
  output word_t instr_address,
  output word_t data_address,
  output word_t data_writedata,
  output logic  data_read,
  output logic  data_write,
  output word_t register_v0,
  output word_t register_v3
);

  word_t     pc;
  word_t     pc_plus4;
  word_t     pc_next;
  word_t     branch_target;
  word_t     jump_target;
  word_t     imm_sext;
  word_t     imm_ext;
  word_t     rs_val;
  word_t     rt_val;
  word_t     alu_b;
  word_t     alu_result;
  word_t     wb_data;
  reg_addr_t wb_addr;
  logic      alu_zero;
  logic      branch_taken;
  logic      advance;

  // a pc of zero means halted and nothing further executes
  assign advance = clk_enable && (pc != '0);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc <= RESET_VECTOR;
    end else if (advance) begin
      pc <= pc_next;
    end
  end

  assign instr_address = pc;
  assign pc_plus4      = pc + 32'd4;

  assign imm_sext = {{16{instr_readdata[15]}}, instr_readdata[15:0]};
  assign imm_ext  = ctrl.imm_zero_ext ? {16'h0000, instr_readdata[15:0]} : imm_sext;
  assign alu_b    = ctrl.alu_src_imm ? imm_ext : rt_val;

  mips_regfile u_regfile (
    .clk        (clk),
    .rst_n      (rst_n),
    .we         (ctrl.reg_write && advance),
    .ra1        (instr_readdata[25:21]),
    .ra2        (instr_readdata[20:16]),
    .wa         (wb_addr),
    .wd         (wb_data),
    .rd1        (rs_val),
    .rd2        (rt_val),
    .register_v0(register_v0),
    .register_v3(register_v3)
  );

  mips_alu u_alu (
    .op    (ctrl.alu_op),
    .a     (rs_val),
    .b     (alu_b),
    .shamt (instr_readdata[10:6]),
    .result(alu_result),
    .zero  (alu_zero)
  );

  always_comb begin
    case (ctrl.dst_sel)
      DST_RD:  wb_addr = instr_readdata[15:11];
      DST_RA:  wb_addr = 5'd31;
      default: wb_addr = instr_readdata[20:16];
    endcase
  end

  always_comb begin
    case (ctrl.wb_sel)
      WB_MEM:  wb_data = data_readdata;
      WB_LINK: wb_data = pc_plus4; // without a delay slot the return is pc + 4
      default: wb_data = alu_result;
    endcase
  end

  assign branch_taken  = (ctrl.branch_eq && alu_zero) || (ctrl.branch_ne && !alu_zero);
  assign branch_target = pc_plus4 + {imm_sext[29:0], 2'b00};
  assign jump_target   = {pc_plus4[31:28], instr_readdata[25:0], 2'b00};

  always_comb begin
    if (ctrl.jump_reg) begin
      pc_next = rs_val;
    end else if (ctrl.jump) begin
      pc_next = jump_target;
    end else if (branch_taken) begin
      pc_next = branch_target;
    end else begin
      pc_next = pc_plus4;
    end
  end

  assign data_address   = alu_result;
  assign data_writedata = rt_val;
  assign data_read      = ctrl.mem_read && advance;
  assign data_write     = ctrl.mem_write && advance;

  a_pc_aligned: assert property (@(posedge clk) disable iff (!rst_n) pc[1:0] == 2'b00)
    else $error("pc left word alignment: %h", pc);

endmodule

`default_nettype wire

/* src/mips_cpu_harvard.sv */
`timescale 1ns/1ps
`default_nettype none

module mips_cpu_harvard import mips_pkg::*; #(
  parameter word_t RESET_VECTOR = 32'hbfc0_0000
) (
  input  logic  clk,
  input  logic  rst_n,
  input  logic  clk_enable,
  output logic  active,
  output word_t register_v0,
  output word_t register_v3,
  output word_t instr_address,
  input  word_t instr_readdata,
  output word_t data_address,
  output logic  data_write,
  output logic  data_read,
  output word_t data_writedata,
  input  word_t data_readdata
);

  ctrl_t ctrl;

  mips_controller u_controller (
    .instr(instr_readdata),
    .ctrl (ctrl)
  );

  mips_datapath #(
    .RESET_VECTOR(RESET_VECTOR)
  ) u_datapath (
    .clk           (clk),
    .rst_n         (rst_n),
    .clk_enable    (clk_enable),
    .ctrl          (ctrl),
    .instr_readdata(instr_readdata),
    .data_readdata (data_readdata),
    .instr_address (instr_address),
    .data_address  (data_address),
    .data_writedata(data_writedata),
    .data_read     (data_read),
    .data_write    (data_write),
    .register_v0   (register_v0),
    .register_v3   (register_v3)
  );

  // drops one enabled edge after the pc lands on zero
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      active <= 1'b1;
    end else if (clk_enable) begin
      active <= (instr_address != '0);
    end
  end

  a_strobes_idle: assert property (@(posedge clk) disable iff (!rst_n)
    !clk_enable |-> !(data_read || data_write))
    else $error("memory strobe high while the clock enable is low");

endmodule

`default_nettype wire

/* dv/tb_clock.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk   = 1'b0;
    rst_n = 1'b0;
  end

  always #2 clk = ~clk; // 4 ns period

  // low for three rising edges and released 1 ns after the third
  task automatic apply_reset();
    rst_n = 1'b0;
    repeat (3) @(posedge clk);
    #1 rst_n = 1'b1;
  endtask

endmodule

`default_nettype wire

/* dv/tb_mips_cpu_harvard.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_mips_cpu_harvard import mips_pkg::*; ();

  localparam word_t RV     = 32'hbfc0_0000; // default reset vector of the core
  localparam int    NTESTS = 6;

  logic  clk;
  logic  rst_n;
  logic  clk_enable;
  logic  active;
  logic  data_write;
  logic  data_read;
  word_t register_v0;
  word_t register_v3;
  word_t instr_address;
  word_t instr_readdata;
  word_t data_address;
  word_t data_writedata;
  word_t data_readdata;
  word_t instr_off;

  word_t imem [64];
  word_t dmem [64];
  word_t img [NTESTS][64]; // one program image per test
  int    len [NTESTS];
  int    cur;
  string names [NTESTS] = '{"alu", "memory", "control", "zero_reg", "stall", "halt"};

  // ISA model state
  word_t ref_pc;
  word_t exp_addr;
  word_t exp_wdata;
  word_t ref_regs [32];
  word_t ref_mem [64];
  logic  ref_active;
  logic  exp_we;
  logic  exp_re;

  bit running;
  int errors;
  int passed;
  int failed;
  int cycles;
  int limit = 1_000_000;

  tb_clock clk_gen (.clk(clk), .rst_n(rst_n));

  mips_cpu_harvard dut0 (.*);

  // instruction memory sits at the reset vector and data memory at address zero
  assign instr_off      = instr_address - RV;
  assign instr_readdata = (instr_off < 32'd256) ? imem[instr_off[7:2]] : '0;
  assign data_readdata  = dmem[data_address[7:2]];

  always @(posedge clk) begin
    if (data_write) begin
      dmem[data_address[7:2]] <= data_writedata;
    end
  end

  function automatic word_t fill(word_t addr);
    return {addr[15:0], addr[31:16]} ^ ~addr;
  endfunction

  function automatic word_t fetch(word_t addr);
    return ((addr - RV) < 32'd256) ? imem[(addr - RV) >> 2] : '0; // nop outside the image
  endfunction

  function automatic word_t rtype(funct_t fn, reg_addr_t rs, reg_addr_t rt, reg_addr_t rd,
                                  logic [4:0] sh);
    return {OP_SPECIAL, rs, rt, rd, sh, fn};
  endfunction

  function automatic word_t itype(opcode_t op, reg_addr_t rs, reg_addr_t rt, logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  function automatic word_t jtype(opcode_t op, int idx);
    return {op, 26'((RV + idx * 4) >> 2)}; // idx counts words from the image start
  endfunction

  task automatic emit(input word_t w);
    img[cur][len[cur]] = w;
    len[cur]++;
  endtask

  task automatic load_const(input reg_addr_t r, input word_t v);
    emit(itype(OP_LUI, 0, r, v[31:16]));
    emit(itype(OP_ORI, r, r, v[15:0]));
  endtask

  // executes one instruction on the model without delay slots
  function automatic void ref_step();
    word_t     instr;
    word_t     a;
    word_t     b;
    word_t     se;
    word_t     ze;
    word_t     next;
    word_t     val;
    reg_addr_t dst;
    instr      = fetch(ref_pc);
    ref_active = (ref_pc != '0);
    if (!ref_active) return;
    a        = ref_regs[instr[25:21]];
    b        = ref_regs[instr[20:16]];
    se       = {{16{instr[15]}}, instr[15:0]};
    ze       = {16'h0000, instr[15:0]};
    exp_addr = a + se;
    next     = ref_pc + 32'd4;
    dst      = '0; // register zero as target means no write
    val      = '0;
    case (instr[31:26])
      OP_SPECIAL: begin
        dst = instr[15:11];
        case (instr[5:0])
          FN_ADDU: val = a + b;
          FN_SUBU: val = a - b;
          FN_AND:  val = a & b;
          FN_OR:   val = a | b;
          FN_XOR:  val = a ^ b;
          FN_SLT:  val = word_t'($signed(a) < $signed(b));
          FN_SLTU: val = word_t'(a < b);
          FN_SLL:  val = b << instr[10:6];
          FN_SRL:  val = b >> instr[10:6];
          FN_JR: begin
            dst  = '0;
            next = a;
          end
          default: dst = '0;
        endcase
      end
      OP_ADDIU, OP_SLTI, OP_ANDI, OP_ORI, OP_XORI, OP_LUI: begin
        dst = instr[20:16];
        case (instr[31:26])
          OP_ADDIU: val = a + se;
          OP_SLTI:  val = word_t'($signed(a) < $signed(se));
          OP_ANDI:  val = a & ze;
          OP_ORI:   val = a | ze;
          OP_XORI:  val = a ^ ze;
          default:  val = {instr[15:0], 16'h0000};
        endcase
      end
      OP_LW: begin
        exp_re = 1'b1;
        dst    = instr[20:16];
        val    = ref_mem[exp_addr[7:2]];
      end
      OP_SW: begin
        ref_mem[exp_addr[7:2]] = b;
        exp_we    = 1'b1;
        exp_wdata = b;
      end
      OP_BEQ: if (a == b) next = next + (se << 2);
      OP_BNE: if (a != b) next = next + (se << 2);
      OP_J:   next = {next[31:28], instr[25:0], 2'b00};
      OP_JAL: begin
        dst  = 5'd31;
        val  = next;
        next = {next[31:28], instr[25:0], 2'b00};
      end
      default: ;
    endcase
    if (dst != '0) ref_regs[dst] = val;
    ref_pc = next;
  endfunction

  task automatic load_image(input int t);
    for (int i = 0; i < 64; i++) begin
      imem[i]    = img[t][i];
      dmem[i]    = fill(word_t'(i * 4));
      ref_mem[i] = dmem[i];
    end
    for (int i = 0; i < 32; i++) begin
      ref_regs[i] = '0;
    end
    ref_pc     = RV;
    ref_active = 1'b1;
  endtask

  task automatic build(input int t);
    word_t a;
    word_t b;
    a   = $urandom;
    b   = $urandom;
    cur = t;
    for (int i = 0; i < 64; i++) begin
      img[t][i] = '0;
    end
    len[t] = 0;
    case (t)
      0: begin
        load_const(8, a);
        load_const(9, b);
        emit(rtype(FN_ADDU, 8, 9, REG_V0, 0));
        emit(rtype(FN_SUBU, 8, 9, REG_V3, 0));
        emit(rtype(FN_AND, 8, 9, REG_V0, 0));
        emit(rtype(FN_OR, 8, 9, REG_V3, 0));
        emit(rtype(FN_XOR, 8, 9, REG_V0, 0));
        emit(rtype(FN_SLT, 8, 9, REG_V3, 0));
        emit(rtype(FN_SLTU, 9, 8, REG_V0, 0));
        emit(rtype(FN_SLL, 0, 9, REG_V3, 5'($urandom)));
        emit(rtype(FN_SRL, 0, 8, REG_V0, 5'($urandom)));
        emit(itype(OP_ADDIU, 8, REG_V3, 16'($urandom)));
        emit(itype(OP_ANDI, 9, REG_V0, 16'($urandom)));
        emit(itype(OP_ORI, 8, REG_V3, 16'($urandom)));
        emit(itype(OP_XORI, 9, REG_V0, 16'($urandom)));
        emit(itype(OP_SLTI, 8, REG_V3, 16'($urandom)));
        emit(itype(OP_LUI, 0, REG_V0, 16'($urandom)));
      end
      1, 4: begin
        load_const(8, a);
        load_const(9, b);
        emit(itype(OP_SW, 0, 8, 16'h0040));
        emit(itype(OP_SW, 0, 9, 16'h0044));
        emit(itype(OP_LW, 0, REG_V0, 16'h0040));
        emit(itype(OP_LW, 0, REG_V3, 16'h0044));
        emit(itype(OP_LW, 0, REG_V0, 16'h0080)); // untouched word keeps the fill
        emit(itype(OP_ADDIU, 0, 10, 16'h0010));
        emit(itype(OP_SW, 10, REG_V3, 16'hfffc)); // negative offset
        emit(itype(OP_LW, 10, REG_V0, 16'hfffc));
      end
      2: begin
        emit(itype(OP_ADDIU, 0, 8, 16'd5));
        emit(itype(OP_ADDIU, 0, 9, 16'd5));
        emit(itype(OP_BEQ, 8, 9, 16'd1)); // taken
        emit(itype(OP_ADDIU, 0, REG_V0, 16'd1));
        emit(itype(OP_BNE, 8, 9, 16'd1)); // not taken
        emit(itype(OP_ADDIU, 0, REG_V3, 16'd2));
        emit(itype(OP_BNE, 8, 0, 16'd1)); // taken
        emit(itype(OP_ADDIU, 0, REG_V0, 16'd3));
        emit(itype(OP_BEQ, 8, 0, 16'd1)); // not taken
        emit(itype(OP_ADDIU, REG_V0, REG_V0, 16'd4));
        emit(jtype(OP_JAL, len[t] + 3)); // call the subroutine below
        emit(itype(OP_ADDIU, REG_V3, REG_V3, 16'd16));
        emit(jtype(OP_J, len[t] + 3)); // skip over it to the halt
        emit(itype(OP_ADDIU, REG_V0, REG_V0, 16'd32));
        emit(rtype(FN_JR, 31, 0, 0, 0));
      end
      3: begin
        emit(itype(OP_ADDIU, 0, REG_V3, 16'd7));
        emit(itype(OP_ADDIU, REG_V3, 0, 16'h0055));
        emit(itype(OP_LUI, 0, 0, a[15:0]));
        emit(rtype(FN_ADDU, 0, 0, REG_V0, 0));
        emit(rtype(FN_OR, 0, 0, REG_V3, 0));
      end
      default: begin
        load_const(REG_V0, a);
        emit(itype(OP_XORI, REG_V0, REG_V3, b[15:0]));
      end
    endcase
    emit(rtype(FN_JR, 0, 0, 0, 0)); // jump to address zero halts the core
  endtask

  task automatic check_word(input string name, input word_t exp, input word_t act);
    if (act !== exp) begin
      errors++;
      $display("Fail %0t %s expected %h got %h", $time, name, exp, act);
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      errors++;
      $display("Fail %0t %s expected %b got %b", $time, name, exp, act);
    end
  endtask

  // outputs are settled at the falling edge halfway between drive and capture
  always @(negedge clk) begin
    if (running) begin
      check_word("instr_address", ref_pc, instr_address);
      check_word("register_v0", ref_regs[REG_V0], register_v0);
      check_word("register_v3", ref_regs[REG_V3], register_v3);
      check_bit("active", ref_active, active);
      exp_we = 1'b0;
      exp_re = 1'b0;
      if (clk_enable) ref_step();
      check_bit("data_write", exp_we, data_write);
      check_bit("data_read", exp_re, data_read);
      if (exp_we || exp_re) begin
        check_word("data_address", exp_addr, data_address);
      end
      if (exp_we) begin
        check_word("data_writedata", exp_wdata, data_writedata);
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > limit) begin
      $display("timeout after %0d cycles, the program never halted", cycles);
      $display("TEST FAILED");
      $finish;
    end
  end

  task automatic run_test(input int t);
    int errs_before;
    errs_before = errors;
    clk_enable  = 1'b0;
    load_image(t);
    clk_gen.apply_reset();
    running = 1'b1;
    do begin
      clk_enable = (t == 4) ? (($urandom % 4) != 0) : 1'b1;
      @(posedge clk);
      #1;
    end while (active);
    clk_enable = 1'b0;
    @(negedge clk); // one more compare on the halted state
    #1 running = 1'b0;
    for (int i = 0; i < 64; i++) begin
      check_word($sformatf("dmem[%0d]", i), ref_mem[i], dmem[i]);
    end
    if (errors == errs_before) begin
      passed++;
      $display("test %s passed", names[t]);
    end else begin
      failed++;
      $display("test %s failed with %0d errors", names[t], errors - errs_before);
    end
  endtask

  initial begin
    int total;
    int steps;
    void'($urandom(85));
    clk_enable = 1'b0;
    running    = 1'b0;
    total      = 0;
    // dry run of the model gives the length of every program
    for (int t = 0; t < NTESTS; t++) begin
      build(t);
      load_image(t);
      steps = 0;
      while (ref_active && steps < 10000) begin
        ref_step();
        steps++;
      end
      total += steps;
    end
    limit = 2 * total + 100;
    for (int t = 0; t < NTESTS; t++) begin
      run_test(t);
    end
    $display("%0d tests passed, %0d tests failed", passed, failed);
    if (failed == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* mips_cpu_harvard.f */
src/mips_pkg.sv
src/mips_alu.sv
src/mips_regfile.sv
src/mips_controller.sv
src/mips_datapath.sv
src/mips_cpu_harvard.sv
dv/tb_clock.sv
dv/tb_mips_cpu_harvard.sv

/* Bender.yml */
package:
  name: mips_cpu_harvard

sources:
  - files:
      - src/mips_pkg.sv
      - src/mips_alu.sv
      - src/mips_regfile.sv
      - src/mips_controller.sv
      - src/mips_datapath.sv
      - src/mips_cpu_harvard.sv
  - target: test
    files:
      - dv/tb_clock.sv
      - dv/tb_mips_cpu_harvard.sv
